//--- flist.f
logic/mchan_cfg_pkg.sv
logic/mchan_types_pkg.sv
logic/ctrl_target_decoder.sv
logic/desc_assembler.sv
logic/sid_allocator.sv
logic/transfer_slot.sv
logic/status_collector.sv
logic/mchan_ctrl_top.sv
testbench/mchan_ctrl_checker.sv
testbench/mchan_ctrl_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the DMA front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module mchan_ctrl_tb --Mdir "$BUILD_DIR" -f flist.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/Vmchan_ctrl_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
   exit 1
fi
exit 0

//--- testbench/mchan_ctrl_tb.sv
// DMA front-end testbench with clock, reset, random stimulus, model and compare tasks
`timescale 1ns/10ps

module mchan_ctrl_tb;
   import mchan_cfg_pkg::*;
   import mchan_types_pkg::*;

   localparam int unsigned CLK_PERIOD = 40;
   localparam int unsigned N_ROUNDS   = 16;
   localparam int unsigned N_OPS      = 12 + N_ROUNDS * 12;  // Accesses and done reports
   localparam int unsigned MAX_CYCLES = 40 * N_OPS;

   logic        clk_i;
   logic        rst_ni;
   ctrl_req_t   ctrl_req_i;
   logic        ctrl_gnt_o;
   ctrl_rsp_t   ctrl_rsp_o;
   dma_desc_t   desc_o;
   logic        desc_valid_o;
   logic        desc_ready_i;
   done_t       done_i;

   slot_vec_t   model_alloc;
   slot_vec_t   model_done;
   sid_t        cur_sid;            // Last SID handed out
   dma_desc_t   desc_q[$];          // Expected descriptors in issue order
   int unsigned cycles = 0;

   mchan_ctrl_top mchan_ctrl_top_inst
   (
      .clk_i        ( clk_i        ),
      .rst_ni       ( rst_ni       ),
      .ctrl_req_i   ( ctrl_req_i   ),
      .ctrl_gnt_o   ( ctrl_gnt_o   ),
      .ctrl_rsp_o   ( ctrl_rsp_o   ),
      .desc_o       ( desc_o       ),
      .desc_valid_o ( desc_valid_o ),
      .desc_ready_i ( desc_ready_i ),
      .done_i       ( done_i       )
   );

   bind mchan_ctrl_top mchan_ctrl_checker mchan_ctrl_checker_inst
   (
      .clk_i        ( clk_i        ),
      .rst_ni       ( rst_ni       ),
      .ctrl_req_i   ( ctrl_req_i   ),
      .ctrl_gnt_i   ( ctrl_gnt_o   ),
      .ctrl_rsp_i   ( ctrl_rsp_o   ),
      .desc_i       ( desc_o       ),
      .desc_valid_i ( desc_valid_o ),
      .desc_ready_i ( desc_ready_i ),
      .free_i       ( free_vec     )
   );

   always #(CLK_PERIOD/2) clk_i = ~clk_i;

   always @(posedge clk_i)
   begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES)
      begin
         fail_run("Timeout: the run exceeded its cycle limit");
      end
   end

   // **************************************************
   // Reporting and compare tasks
   // **************************************************
   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1, "Simulation stopped on first error");
   endtask

   task automatic check_rsp(input ctrl_rsp_t got, input ctrl_rsp_t exp);
      if (got !== exp)
      begin
         fail_run($sformatf("MISMATCH ctrl_rsp_o: got %h expected %h", got, exp));
      end
   endtask

   task automatic check_desc(input dma_desc_t got, input dma_desc_t exp);
      if (got !== exp)
      begin
         fail_run($sformatf("MISMATCH desc_o: got %h expected %h", got, exp));
      end
   endtask

   task automatic check_status(input status_word_t got, input status_word_t exp);
      if (got !== exp)
      begin
         fail_run($sformatf("MISMATCH ctrl_rsp_o.r_data status: got %h expected %h", got, exp));
      end
   endtask

   // **************************************************
   // Model helpers
   // **************************************************
   function automatic sid_t lowest_free(input slot_vec_t alloc);
      for (int i = 0; i < NB_TRANSFERS; i++)
      begin
         if (!alloc[i])
         begin
            return sid_t'(i);
         end
      end
      return '0;
   endfunction

   function automatic ctrl_rsp_t expect_rsp(input pe_id_t id, input logic [DATA_WIDTH-1:0] data);
      return '{r_valid: 1'b1, r_data: data, id: id};
   endfunction

   function automatic pe_id_t rand_id();
      return pe_id_t'($urandom());
   endfunction

   // **************************************************
   // Bus access tasks
   // **************************************************
   // Holds the request until granted and takes the response a cycle later
   task automatic access(input logic rd, input logic [REG_ADD_WIDTH-1:0] addr,
                         input logic [DATA_WIDTH-1:0] wdata, input pe_id_t id,
                         output ctrl_rsp_t rsp);
      @(negedge clk_i);
      ctrl_req_i = '{req: 1'b1, rd: rd, addr: addr, wdata: wdata, id: id};
      #(CLK_PERIOD/4);
      while (!ctrl_gnt_o)
      begin
         @(negedge clk_i);
         #(CLK_PERIOD/4);
      end
      @(negedge clk_i);
      rsp        = ctrl_rsp_o;
      ctrl_req_i = '0;
   endtask

   task automatic write_reg(input logic [REG_ADD_WIDTH-1:0] addr,
                            input logic [DATA_WIDTH-1:0] wdata, input pe_id_t id);
      ctrl_rsp_t rsp;
      access(1'b0, addr, wdata, id, rsp);
      rsp.r_data = '0;   // No read data on writes
      check_rsp(rsp, expect_rsp(id, '0));
   endtask

   task automatic id_read(input pe_id_t id);
      ctrl_rsp_t rsp;
      sid_t      sid;
      sid = lowest_free(model_alloc);
      access(1'b1, CMD_REG_ADDR, '0, id, rsp);
      check_rsp(rsp, expect_rsp(id, DATA_WIDTH'(sid)));
      model_alloc[sid] = 1'b1;
      cur_sid          = sid;
   endtask

   task automatic status_read(input pe_id_t id);
      ctrl_rsp_t    rsp;
      status_word_t exp;
      // Done bits from bit 0, alloc bits from bit 16
      exp = status_word_t'((DATA_WIDTH'(model_alloc) << ALLOC_STATUS_LSB) |
                           DATA_WIDTH'(model_done));
      access(1'b1, STATUS_REG_ADDR, '0, id, rsp);
      check_status(status_word_t'(rsp.r_data), exp);
      check_rsp(rsp, expect_rsp(id, DATA_WIDTH'(exp)));
   endtask

   task automatic clear_write(input logic [DATA_WIDTH-1:0] wdata, input pe_id_t id);
      write_reg(STATUS_REG_ADDR, wdata, id);
      model_alloc = model_alloc & ~wdata[NB_TRANSFERS-1:0];
      model_done  = model_done & ~wdata[NB_TRANSFERS-1:0];
   endtask

   // Command word, then TCDM address, then external address
   task automatic enqueue(input pe_id_t id);
      logic [DATA_WIDTH-1:0] w_cmd;
      logic [DATA_WIDTH-1:0] w_tcdm;
      logic [DATA_WIDTH-1:0] w_ext;
      dma_desc_t             exp;
      w_cmd        = $urandom();
      w_tcdm       = $urandom();
      w_ext        = $urandom();
      exp.sid      = cur_sid;
      exp.len      = w_cmd[LEN_WIDTH-1:0] - 16'd1;   // Length field from bit 0
      exp.opc      = w_cmd[LEN_WIDTH];
      exp.inc      = w_cmd[LEN_WIDTH + 1];
      exp.ele      = w_cmd[LEN_WIDTH + 2];
      exp.ile      = w_cmd[LEN_WIDTH + 3];
      exp.ble      = w_cmd[LEN_WIDTH + 4];
      exp.tcdm_add = w_tcdm[TCDM_ADD_WIDTH-1:0];
      exp.ext_add  = w_ext[EXT_ADD_WIDTH-1:0];
      write_reg(CMD_REG_ADDR, w_cmd, id);
      write_reg(CMD_REG_ADDR, w_tcdm, id);
      desc_q.push_back(exp);
      write_reg(CMD_REG_ADDR, w_ext, id);
   endtask

   task automatic report_done(input sid_t sid);
      @(negedge clk_i);
      done_i = '{valid: 1'b1, sid: sid};
      @(negedge clk_i);
      done_i = '0;
      if (model_alloc[sid])
      begin
         model_done[sid] = 1'b1;   // Free slots ignore reports
      end
   endtask

   // Random back-pressure and in-order check of accepted descriptors
   always @(negedge clk_i)
   begin
      desc_ready_i = ($urandom_range(3) != 0);
      #(CLK_PERIOD/4);
      if (rst_ni && desc_valid_o && desc_ready_i)
      begin
         if (desc_q.size() == 0)
         begin
            fail_run("A descriptor was issued with no command pending");
         end
         else
         begin
            check_desc(desc_o, desc_q.pop_front());
         end
      end
   end

   // **************************************************
   // Stimulus
   // **************************************************
   initial
   begin
      logic [DATA_WIDTH-1:0] wdata;
      void'($urandom(34089));
      clk_i        = 1'b0;
      rst_ni       = 1'b0;
      ctrl_req_i   = '0;
      desc_ready_i = 1'b0;
      done_i       = '0;
      model_alloc  = '0;
      model_done   = '0;
      cur_sid      = '0;
      repeat (16) @(negedge clk_i);
      rst_ni = 1'b1;

      // Fill every slot so that a fifth read stalls
      for (int i = 0; i < NB_TRANSFERS; i++)
      begin
         id_read(rand_id());
      end
      @(negedge clk_i);
      ctrl_req_i = '{req: 1'b1, rd: 1'b1, addr: CMD_REG_ADDR, wdata: '0, id: rand_id()};
      repeat (6)
      begin
         #(CLK_PERIOD/4);
         if (ctrl_gnt_o)
         begin
            fail_run("ID read was granted while every slot was allocated");
         end
         @(negedge clk_i);
      end
      ctrl_req_i = '0;
      wdata      = $urandom();
      wdata[NB_TRANSFERS-1:0] = slot_vec_t'($urandom_range(1, (1 << NB_TRANSFERS) - 1));
      clear_write(wdata, rand_id());
      id_read(rand_id());
      status_read(rand_id());

      for (int r = 0; r < N_ROUNDS; r++)
      begin
         if (model_alloc == '1)
         begin
            wdata = $urandom();
            wdata[$urandom_range(NB_TRANSFERS - 1)] = 1'b1;   // Free one slot at least
            clear_write(wdata, rand_id());
         end
         id_read(rand_id());
         enqueue(rand_id());
         repeat ($urandom_range(1, 3)) report_done(sid_t'($urandom()));
         status_read(rand_id());
         if ($urandom_range(1) == 1)
         begin
            clear_write($urandom(), rand_id());
            status_read(rand_id());
         end
      end

      while ((desc_q.size() != 0) || desc_valid_o)
      begin
         @(negedge clk_i);
      end
      $display("Test OK");
      $finish;
   end

endmodule

//--- testbench/mchan_ctrl_checker.sv
// Concurrent assertions on the control target and descriptor handshakes
`timescale 1ns/10ps

module mchan_ctrl_checker
(
   input  logic                       clk_i,
   input  logic                       rst_ni,
   input  mchan_types_pkg::ctrl_req_t ctrl_req_i,
   input  logic                       ctrl_gnt_i,
   input  mchan_types_pkg::ctrl_rsp_t ctrl_rsp_i,
   input  mchan_types_pkg::dma_desc_t desc_i,
   input  logic                       desc_valid_i,
   input  logic                       desc_ready_i,
   input  mchan_types_pkg::slot_vec_t free_i
);
   import mchan_cfg_pkg::*;

   logic id_rd;

   assign id_rd = ctrl_req_i.req && ctrl_req_i.rd && (ctrl_req_i.addr == CMD_REG_ADDR);

   // **************************************************
   // Control target
   // **************************************************
   rsp_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      ctrl_gnt_i |=> ctrl_rsp_i.r_valid)
      else $error("read-valid missing one cycle after grant");

   rsp_only_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !ctrl_gnt_i |=> !ctrl_rsp_i.r_valid)
      else $error("read-valid without a grant in the previous cycle");

   no_id_gnt_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (id_rd && (free_i == '0)) |-> !ctrl_gnt_i)
      else $error("ID read granted while no slot is free");

   // **************************************************
   // Descriptor port and reset values
   // **************************************************
   desc_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (desc_valid_i && !desc_ready_i) |=> (desc_valid_i && $stable(desc_i)))
      else $error("descriptor changed or dropped while not accepted");

   reset_quiet: assert property (@(posedge clk_i)
      !rst_ni |-> (!desc_valid_i && !ctrl_gnt_i && !ctrl_rsp_i.r_valid))
      else $error("handshake output high during reset");

endmodule

//--- logic/mchan_ctrl_top.sv
// DMA command front end top level: decoder, assembler, allocator, slots and status collector
`timescale 1ns/10ps

module mchan_ctrl_top
(
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  mchan_types_pkg::ctrl_req_t  ctrl_req_i,
   output logic                        ctrl_gnt_o,
   output mchan_types_pkg::ctrl_rsp_t  ctrl_rsp_o,
   output mchan_types_pkg::dma_desc_t  desc_o,
   output logic                        desc_valid_o,
   input  logic                        desc_ready_i,
   input  mchan_types_pkg::done_t      done_i
);
   import mchan_cfg_pkg::*;
   import mchan_types_pkg::*;

   logic         alloc_req;
   logic         alloc_gnt;      // Granted ID read, also restarts the assembler
   sid_t         cur_sid;
   logic         cmd_wr;
   ctrl_word_u   cmd_word;
   logic         cmd_ready;
   slot_vec_t    clear_vec;
   slot_vec_t    alloc_vec;
   slot_vec_t    allocated_vec;
   slot_vec_t    done_vec;
   slot_vec_t    free_vec;
   status_word_t status_word;

   ctrl_target_decoder ctrl_target_decoder_inst
   (
      .clk_i       ( clk_i        ),
      .rst_ni      ( rst_ni       ),
      .ctrl_req_i  ( ctrl_req_i   ),
      .ctrl_gnt_o  ( ctrl_gnt_o   ),
      .ctrl_rsp_o  ( ctrl_rsp_o   ),
      .status_i    ( status_word  ),
      .sid_i       ( cur_sid      ),
      .alloc_req_o ( alloc_req    ),
      .alloc_gnt_i ( alloc_gnt    ),
      .cmd_wr_o    ( cmd_wr       ),
      .cmd_word_o  ( cmd_word     ),
      .cmd_ready_i ( cmd_ready    ),
      .clear_o     ( clear_vec    )
   );

   desc_assembler desc_assembler_inst
   (
      .clk_i        ( clk_i        ),
      .rst_ni       ( rst_ni       ),
      .restart_i    ( alloc_gnt    ),
      .cmd_wr_i     ( cmd_wr       ),
      .cmd_word_i   ( cmd_word     ),
      .cmd_ready_o  ( cmd_ready    ),
      .sid_i        ( cur_sid      ),
      .desc_o       ( desc_o       ),
      .desc_valid_o ( desc_valid_o ),
      .desc_ready_i ( desc_ready_i )
   );

   sid_allocator sid_allocator_inst
   (
      .clk_i       ( clk_i     ),
      .rst_ni      ( rst_ni    ),
      .alloc_req_i ( alloc_req ),
      .free_i      ( free_vec  ),
      .alloc_gnt_o ( alloc_gnt ),
      .alloc_o     ( alloc_vec ),
      .sid_o       ( cur_sid   )
   );

   // **************************************************
   // One slot per transfer ID
   // **************************************************
   for (genvar i = 0; i < NB_TRANSFERS; i++)
   begin : g_slot
      transfer_slot #(.SLOT_IDX(i)) transfer_slot_inst
      (
         .clk_i       ( clk_i            ),
         .rst_ni      ( rst_ni           ),
         .alloc_i     ( alloc_vec[i]     ),
         .clear_i     ( clear_vec[i]     ),
         .done_i      ( done_i           ),
         .allocated_o ( allocated_vec[i] ),
         .done_o      ( done_vec[i]      )
      );
   end

   status_collector status_collector_inst
   (
      .allocated_i ( allocated_vec ),
      .done_i      ( done_vec      ),
      .free_o      ( free_vec      ),
      .status_o    ( status_word   )
   );

endmodule

//--- logic/status_collector.sv
// Status collector: free vector and packed status word from the slot states
`timescale 1ns/10ps

module status_collector
(
   input  mchan_types_pkg::slot_vec_t    allocated_i,
   input  mchan_types_pkg::slot_vec_t    done_i,
   output mchan_types_pkg::slot_vec_t    free_o,
   output mchan_types_pkg::status_word_t status_o
);

   assign free_o = ~allocated_i;   // Feeds the allocator

   // Done bits low, alloc bits from the upper half
   always_comb
   begin
      status_o         = '0;
      status_o.done    = done_i;
      status_o.alloc   = allocated_i;
   end

endmodule

//--- logic/transfer_slot.sv
// Transfer slot: allocated and done state of one transfer ID
`timescale 1ns/10ps

module transfer_slot
#(
   parameter int unsigned SLOT_IDX = 0
)
(
   input  logic                   clk_i,
   input  logic                   rst_ni,
   input  logic                   alloc_i,
   input  logic                   clear_i,
   input  mchan_types_pkg::done_t done_i,
   output logic                   allocated_o,
   output logic                   done_o
);
   import mchan_types_pkg::*;

   logic allocated_q;
   logic done_q;
   logic done_hit;

   // Reports for free slots are dropped
   assign done_hit = done_i.valid && (done_i.sid == sid_t'(SLOT_IDX)) && allocated_q;

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         allocated_q <= 1'b0;
         done_q      <= 1'b0;
      end
      else
      begin
         if (alloc_i)
            allocated_q <= 1'b1;
         else if (clear_i)
            allocated_q <= 1'b0;

         if (clear_i)
            done_q <= 1'b0;   // Clear wins over a same-cycle report
         else if (done_hit)
            done_q <= 1'b1;
      end
   end

   assign allocated_o = allocated_q;
   assign done_o      = done_q;

endmodule

//--- logic/sid_allocator.sv
// Transfer ID allocator: lowest-free slot pick, one-hot alloc and current SID register
`timescale 1ns/10ps

module sid_allocator
(
   input  logic                       clk_i,
   input  logic                       rst_ni,
   input  logic                       alloc_req_i,
   input  mchan_types_pkg::slot_vec_t free_i,
   output logic                       alloc_gnt_o,
   output mchan_types_pkg::slot_vec_t alloc_o,
   output mchan_types_pkg::sid_t      sid_o
);
   import mchan_cfg_pkg::*;
   import mchan_types_pkg::*;

   sid_t lowest_free;
   sid_t sid_q;

   // Downward scan leaves the lowest free index
   always_comb
   begin
      lowest_free = '0;
      for (int i = NB_TRANSFERS - 1; i >= 0; i--)
      begin
         if (free_i[i])
         begin
            lowest_free = sid_t'(i);
         end
      end
   end

   assign alloc_gnt_o = alloc_req_i && (|free_i);
   assign alloc_o     = alloc_gnt_o ? (slot_vec_t'(1) << lowest_free) : '0;

   // Current transfer ID
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         sid_q <= '0;
      end
      else if (alloc_gnt_o)
      begin
         sid_q <= lowest_free;
      end
   end

   assign sid_o = sid_q;

endmodule

//--- logic/desc_assembler.sv
// Command-word sequencer and descriptor output register with valid/ready handshake
`timescale 1ns/10ps

module desc_assembler
(
   input  logic                        clk_i,
   input  logic                        rst_ni,
   input  logic                        restart_i,
   input  logic                        cmd_wr_i,
   input  mchan_types_pkg::ctrl_word_u cmd_word_i,
   output logic                        cmd_ready_o,
   input  mchan_types_pkg::sid_t       sid_i,
   output mchan_types_pkg::dma_desc_t  desc_o,
   output logic                        desc_valid_o,
   input  logic                        desc_ready_i
);
   import mchan_cfg_pkg::*;
   import mchan_types_pkg::*;

   typedef enum logic [1:0] {
      PH_CMD,    // Expect command word
      PH_TCDM,   // Expect local address
      PH_EXT     // Expect external address
   } phase_e;

   phase_e                    phase_q;
   cmd_word_t                 cmd_q;
   logic [TCDM_ADD_WIDTH-1:0] tcdm_q;
   dma_desc_t                 desc_q;
   logic                      desc_valid_q;
   logic                      desc_load;

   // Only the last word needs room in the descriptor register
   assign cmd_ready_o = (phase_q != PH_EXT) || !desc_valid_q || desc_ready_i;
   assign desc_load   = cmd_wr_i && (phase_q == PH_EXT);

   // **************************************************
   // Phase sequencing
   // **************************************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         phase_q <= PH_CMD;
      end
      else if (restart_i)
      begin
         phase_q <= PH_CMD;   // New SID taken, start over
      end
      else if (cmd_wr_i)
      begin
         case (phase_q)
            PH_CMD:  phase_q <= PH_TCDM;
            PH_TCDM: phase_q <= PH_EXT;
            default: phase_q <= PH_CMD;
         endcase
      end
   end

   // Word capture, union read by phase
   always_ff @(posedge clk_i)
   begin
      if (cmd_wr_i && (phase_q == PH_CMD))
      begin
         cmd_q <= cmd_word_i.cmd;
      end
      if (cmd_wr_i && (phase_q == PH_TCDM))
      begin
         tcdm_q <= cmd_word_i.addr[TCDM_ADD_WIDTH-1:0];
      end
   end

   // **************************************************
   // Descriptor register
   // **************************************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         desc_valid_q <= 1'b0;
      end
      else if (desc_load)
      begin
         desc_valid_q <= 1'b1;
      end
      else if (desc_ready_i)
      begin
         desc_valid_q <= 1'b0;   // Accepted
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (desc_load)
      begin
         desc_q.sid      <= sid_i;
         desc_q.len      <= cmd_q.len - 1'b1;   // Stored minus one
         desc_q.opc      <= cmd_q.opc;
         desc_q.inc      <= cmd_q.inc;
         desc_q.ele      <= cmd_q.ele;
         desc_q.ile      <= cmd_q.ile;
         desc_q.ble      <= cmd_q.ble;
         desc_q.tcdm_add <= tcdm_q;
         desc_q.ext_add  <= cmd_word_i.addr[EXT_ADD_WIDTH-1:0];
      end
   end

   assign desc_o       = desc_q;
   assign desc_valid_o = desc_valid_q;

endmodule

//--- logic/ctrl_target_decoder.sv
// Control target decoder: operation decode, per-operation grant and registered response
`timescale 1ns/10ps

module ctrl_target_decoder
(
   input  logic                          clk_i,
   input  logic                          rst_ni,
   input  mchan_types_pkg::ctrl_req_t    ctrl_req_i,
   output logic                          ctrl_gnt_o,
   output mchan_types_pkg::ctrl_rsp_t    ctrl_rsp_o,
   input  mchan_types_pkg::status_word_t status_i,
   input  mchan_types_pkg::sid_t         sid_i,
   output logic                          alloc_req_o,
   input  logic                          alloc_gnt_i,
   output logic                          cmd_wr_o,
   output mchan_types_pkg::ctrl_word_u   cmd_word_o,
   input  logic                          cmd_ready_i,
   output mchan_types_pkg::slot_vec_t    clear_o
);
   import mchan_cfg_pkg::*;
   import mchan_types_pkg::*;

   logic                  cmd_sel;
   logic                  status_sel;
   logic                  id_rd;
   logic                  cmd_wr;
   logic                  status_rd;
   logic                  clr_wr;
   logic                  rsp_valid_q;
   logic                  rsp_is_id_q;     // Response carries the new SID
   pe_id_t                rsp_id_q;
   logic [DATA_WIDTH-1:0] rsp_data_q;

   // **************************************************
   // Address and type decode
   // **************************************************
   assign cmd_sel    = ctrl_req_i.req && (ctrl_req_i.addr == CMD_REG_ADDR);
   assign status_sel = ctrl_req_i.req && (ctrl_req_i.addr == STATUS_REG_ADDR);

   assign id_rd     = cmd_sel    &&  ctrl_req_i.rd;   // Retrieve transfer ID
   assign cmd_wr    = cmd_sel    && !ctrl_req_i.rd;   // Enqueue command word
   assign status_rd = status_sel &&  ctrl_req_i.rd;
   assign clr_wr    = status_sel && !ctrl_req_i.rd;   // Free slots

   // Grant per operation, unmapped offsets stay ungranted
   always_comb
   begin
      ctrl_gnt_o = 1'b0;
      if (id_rd)
      begin
         ctrl_gnt_o = alloc_gnt_i;   // Stalls while all slots busy
      end
      else if (cmd_wr)
      begin
         ctrl_gnt_o = cmd_ready_i;   // Stalls on a held descriptor
      end
      else if (status_rd || clr_wr)
      begin
         ctrl_gnt_o = 1'b1;
      end
   end

   assign alloc_req_o = id_rd;
   assign cmd_wr_o    = cmd_wr && cmd_ready_i;
   assign cmd_word_o  = ctrl_req_i.wdata;
   assign clear_o     = clr_wr ? ctrl_req_i.wdata[NB_TRANSFERS-1:0] : '0;

   // **************************************************
   // Response, one cycle after grant
   // **************************************************
   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         rsp_valid_q <= 1'b0;
         rsp_is_id_q <= 1'b0;
      end
      else
      begin
         rsp_valid_q <= ctrl_gnt_o;
         rsp_is_id_q <= ctrl_gnt_o && id_rd;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (ctrl_gnt_o)
      begin
         rsp_id_q   <= ctrl_req_i.id;
         rsp_data_q <= status_rd ? DATA_WIDTH'(status_i) : '0;
      end
   end

   // The allocator stores the SID on the grant edge
   always_comb
   begin
      ctrl_rsp_o.r_valid = rsp_valid_q;
      ctrl_rsp_o.id      = rsp_id_q;
      if (rsp_is_id_q)
      begin
         ctrl_rsp_o.r_data = DATA_WIDTH'(sid_i);
      end
      else
      begin
         ctrl_rsp_o.r_data = rsp_data_q;
      end
   end

endmodule

//--- logic/mchan_types_pkg.sv
// Packed structs for target access, descriptor, completion and status, control-word union
package mchan_types_pkg;
   import mchan_cfg_pkg::*;

   typedef logic [SID_WIDTH-1:0]    sid_t;
   typedef logic [PE_ID_WIDTH-1:0]  pe_id_t;
   typedef logic [NB_TRANSFERS-1:0] slot_vec_t;

   // **************************************************
   // Control target
   // **************************************************
   typedef struct packed {
      logic                     req;    // Access request
      logic                     rd;     // 1 = read, 0 = write
      logic [REG_ADD_WIDTH-1:0] addr;   // Register offset
      logic [DATA_WIDTH-1:0]    wdata;
      pe_id_t                   id;     // Issuing core
   } ctrl_req_t;

   typedef struct packed {
      logic                  r_valid;
      logic [DATA_WIDTH-1:0] r_data;
      pe_id_t                id;        // Echo of the granted core ID
   } ctrl_rsp_t;

   // First word of a command, length sits at bit 0
   typedef struct packed {
      logic [CMD_SPARE_WIDTH-1:0] spare;
      logic                       ble;  // Broadcast enable
      logic                       ile;  // Interrupt enable
      logic                       ele;  // Event enable
      logic                       inc;  // Incremental addressing
      logic                       opc;  // Direction
      logic [LEN_WIDTH-1:0]       len;  // Bytes
   } cmd_word_t;

   // Same write word, read either as command or as address
   typedef union packed {
      cmd_word_t             cmd;
      logic [DATA_WIDTH-1:0] addr;
   } ctrl_word_u;

   // **************************************************
   // Back end side
   // **************************************************
   typedef struct packed {
      sid_t                      sid;
      logic [LEN_WIDTH-1:0]      len;       // Length minus one
      logic                      opc;
      logic                      inc;
      logic                      ele;
      logic                      ile;
      logic                      ble;
      logic [TCDM_ADD_WIDTH-1:0] tcdm_add;
      logic [EXT_ADD_WIDTH-1:0]  ext_add;
   } dma_desc_t;

   typedef struct packed {
      logic valid;
      sid_t sid;
   } done_t;

   typedef struct packed {
      logic [DATA_WIDTH-ALLOC_STATUS_LSB-NB_TRANSFERS-1:0] rsvd_hi;
      slot_vec_t                                           alloc;
      logic [ALLOC_STATUS_LSB-NB_TRANSFERS-1:0]            rsvd_lo;
      slot_vec_t                                           done;
   } status_word_t;

endpackage

//--- logic/mchan_cfg_pkg.sv
// Widths, slot count and register map of the DMA command front end
package mchan_cfg_pkg;

   // **************************************************
   // Sizes
   // **************************************************
   localparam int unsigned NB_TRANSFERS   = 4;   // Transfer slots
   localparam int unsigned SID_WIDTH      = 2;   // Transfer ID bits
   localparam int unsigned PE_ID_WIDTH    = 2;   // Core ID bits
   localparam int unsigned DATA_WIDTH     = 32;  // Target data bus
   localparam int unsigned REG_ADD_WIDTH  = 4;   // Register offset bits
   localparam int unsigned LEN_WIDTH      = 16;  // Transfer length field
   localparam int unsigned TCDM_ADD_WIDTH = 12;  // Local memory address
   localparam int unsigned EXT_ADD_WIDTH  = 29;  // External address

   // **************************************************
   // Register map
   // **************************************************
   // Command register: read returns a SID, three writes enqueue a transfer
   localparam logic [REG_ADD_WIDTH-1:0] CMD_REG_ADDR    = 4'h0;
   // Status register: read returns done/alloc bits, write clears slots
   localparam logic [REG_ADD_WIDTH-1:0] STATUS_REG_ADDR = 4'h4;

   localparam int unsigned ALLOC_STATUS_LSB = 16;  // Alloc bits start here

   // Unused high bits of a command word
   localparam int unsigned CMD_SPARE_WIDTH = DATA_WIDTH - LEN_WIDTH - 5;

endpackage
